/* flist.f */
src/vdiv_pkg.sv
src/vdiv_uop_reg.sv
src/vdiv_operand_prep.sv
src/vdiv_lane_divider.sv
src/vdiv_result_pack.sv
src/vdiv_unit.sv
verif/vdiv_chk.sv
verif/vdiv_tb.sv

/* Makefile */
TOP = vdiv_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f flist.f

run: compile
	./obj_dir/V$(TOP) | awk '{ print } /^Test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* verif/vdiv_tb.sv */
`default_nettype none
`timescale 1ns/1ps

module vdiv_tb;

  import vdiv_pkg::*;

  localparam int wait_limit = 100;
  localparam int n_vv = 200;
  localparam int n_vx = 100;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;

  logic        clk;
  logic        rst_n;
  logic        uop_valid;
  div_uop_t    uop;
  logic        in_ready;
  logic        result_valid;
  div_result_t result;
  logic        result_ready;

  logic [31:0] lfsr;
  int          checks;
  int          errors;
  int          timeouts;

  vdiv_unit dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .uop_valid    (uop_valid),
    .uop          (uop),
    .in_ready     (in_ready),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

  // dut0 is the only vdiv_unit instance
  bind vdiv_unit vdiv_chk chk0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .uop_valid    (uop_valid),
    .in_ready     (in_ready),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .result       (result)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [63:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[62:0], lfsr[0]};
    end
  endtask

  task automatic check_true(input logic ok, input string msg);
    checks++;
    assert (ok) else begin
      errors++;
      $display("FAILED %0t: %s", $time, msg);
    end
  endtask

  function automatic int eew_bits(eew_e eew);
    case (eew)
      eew8:    return 8;
      eew16:   return 16;
      default: return 32;
    endcase
  endfunction

  function automatic div_op_e op_of(int k);
    case (k)
      0:       return vdivu;
      1:       return vdiv;
      2:       return vremu;
      default: return vrem;
    endcase
  endfunction

  function automatic eew_e eew_of(int k);
    case (k)
      0:       return eew8;
      1:       return eew16;
      default: return eew32;
    endcase
  endfunction

  function automatic logic [31:0] low_ones(int ew);
    return 32'((64'h1 << ew) - 64'h1);
  endfunction

  // one element by the RISC-V divide rules
  function automatic logic [31:0] ref_elem(div_op_e op, int ew, logic [31:0] a,
                                           logic [31:0] b);
    logic   sgn;
    longint sa;
    longint sb;
    longint q;
    longint r;
    sgn = (op == vdiv) || (op == vrem);
    sa = longint'(a);
    sb = longint'(b);
    if (sgn && a[ew-1]) sa = sa - (longint'(1) << ew);
    if (sgn && b[ew-1]) sb = sb - (longint'(1) << ew);
    if (sb == 64'sd0) begin
      q = -64'sd1;
      r = sa;
    end else if (sgn && sa == -(longint'(1) << (ew - 1)) && sb == -64'sd1) begin
      q = sa;
      r = 64'sd0;
    end else begin
      q = sa / sb;
      r = sa % sb;
    end
    if (op == vdivu || op == vdiv) return 32'(q) & low_ones(ew);
    return 32'(r) & low_ones(ew);
  endfunction

  function automatic logic [63:0] expected_data(div_uop_t u);
    int          ew;
    logic [63:0] mask;
    logic [63:0] v1;
    logic [63:0] v2;
    logic [31:0] a;
    logic [31:0] b;
    logic [63:0] data;
    ew = eew_bits(u.eew);
    mask = (64'h1 << ew) - 64'h1;
    v1 = u.vs1;
    v2 = u.vs2;
    data = '0;
    for (int i = 0; i < 64 / ew; i++) begin
      a = 32'((v2 >> (i * ew)) & mask);
      b = (u.form == opmvx) ? (u.rs1 & low_ones(ew)) : 32'((v1 >> (i * ew)) & mask);
      data = data | ({32'h0, ref_elem(u.op, ew, a, b)} << (i * ew));
    end
    return data;
  endfunction

  // zero divisor, overflow pair, small divisor or full random per element
  task automatic rand_operands(input int ew, output logic [63:0] vs1, output logic [63:0] vs2);
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] sel;
    logic [63:0] mask;
    mask = (64'h1 << ew) - 64'h1;
    vs1 = '0;
    vs2 = '0;
    for (int i = 0; i < 64 / ew; i++) begin
      take_bits(ew, a);
      take_bits(ew, b);
      take_bits(3, sel);
      case (sel[2:0])
        3'd0: b = '0;
        3'd1: begin
          a = 64'h1 << (ew - 1);
          b = mask;
        end
        3'd2: b = b & 64'h7;
        default: ;
      endcase
      vs2 = vs2 | ((a & mask) << (i * ew));
      vs1 = vs1 | ((b & mask) << (i * ew));
    end
  endtask

  task automatic make_uop(input src_form_e form, output div_uop_t u);
    logic [63:0] r;
    logic [63:0] sel;
    logic [63:0] vs1;
    logic [63:0] vs2;
    int          ew;
    u = '0;
    take_bits(2, r);
    u.op = op_of(int'(r[1:0]));
    take_bits(2, r);
    u.eew = eew_of(int'(r[1:0]));
    u.form = form;
    take_bits(4, r);
    u.rob_entry = r[3:0];
    ew = eew_bits(u.eew);
    rand_operands(ew, vs1, vs2);
    u.vs1 = vs1;
    u.vs2 = vs2;
    // bits above eew stay random so truncation is exercised
    take_bits(32, r);
    take_bits(2, sel);
    case (sel[1:0])
      2'd0:    u.rs1 = r[31:0] << ew;
      2'd1:    u.rs1 = (r[31:0] << ew) | low_ones(ew);
      2'd2:    u.rs1 = (r[31:0] << ew) | {29'h0, r[2:0]};
      default: u.rs1 = r[31:0];
    endcase
  endtask

  // offer one uop, then drain it under random result_ready
  task automatic run_uop(input div_uop_t u);
    logic [63:0] exp;
    logic [63:0] got;
    logic [63:0] bits;
    div_result_t held;
    logic        seen;
    logic        moved;
    int          cycles;
    if (timeouts != 0) return;
    exp = expected_data(u);
    cycles = 0;
    while (!in_ready && cycles < wait_limit) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!in_ready) begin
      timeouts++;
      $display("timeout: in_ready stayed low, the unit never became free for a new uop");
      return;
    end
    uop = u;
    uop_valid = 1'b1;
    @(posedge clk);
    #1;
    uop_valid = 1'b0;
    check_true(!in_ready, "in_ready still high after accept");
    cycles = 0;
    seen = 1'b0;
    moved = 1'b0;
    held = '0;
    while (!moved && cycles < wait_limit) begin
      take_bits(1, bits);
      result_ready = bits[0];
      if (result_valid) begin
        got = result.w_data;
        if (!seen) begin
          check_true(cycles == 34,
                     $sformatf("result_valid after %0d cycles, expected 34", cycles));
          check_true(got == exp, $sformatf("op %s eew %s form %s: w_data %h, expected %h",
                                           u.op.name(), u.eew.name(), u.form.name(), got, exp));
          check_true(result.rob_entry == u.rob_entry,
                     $sformatf("rob_entry %0d, expected %0d", result.rob_entry, u.rob_entry));
        end else begin
          check_true(result == held, "result changed while result_ready was low");
        end
        seen = 1'b1;
        held = result;
        moved = result_ready;
      end else begin
        check_true(!seen, "result_valid dropped before the transfer");
      end
      check_true(!in_ready, "in_ready high while a uop is in flight");
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!moved) begin
      timeouts++;
      $display("timeout: no result transfer within %0d cycles of the accept", wait_limit);
      return;
    end
    check_true(in_ready && !result_valid, "unit not idle after the result transfer");
    result_ready = 1'b0;
  endtask

  // whole vs1 zero, then rs1 zero in its low eew bits only
  task automatic zero_divisor_tests();
    div_uop_t    u;
    logic [63:0] r;
    for (int k = 0; k < 4; k++) begin
      for (int e = 0; e < 3; e++) begin
        u = '0;
        u.op = op_of(k);
        u.eew = eew_of(e);
        u.form = opmvv;
        u.rob_entry = 4'(k * 3 + e);
        take_bits(64, r);
        u.vs2 = r;
        run_uop(u);
        u.form = opmvx;
        take_bits(32, r);
        u.rs1 = r[31:0] << eew_bits(u.eew);
        run_uop(u);
      end
    end
  endtask

  task automatic overflow_tests();
    div_uop_t    u;
    logic [63:0] r;
    logic [63:0] v2;
    int          ew;
    for (int e = 0; e < 3; e++) begin
      for (int k = 1; k < 4; k += 2) begin
        u = '0;
        u.op = op_of(k);
        u.eew = eew_of(e);
        u.form = opmvv;
        u.rob_entry = 4'(e * 2 + k);
        ew = eew_bits(u.eew);
        v2 = '0;
        for (int i = 0; i < 64 / ew; i++) begin
          v2 = v2 | ((64'h1 << (ew - 1)) << (i * ew));
        end
        u.vs2 = v2;
        u.vs1 = '1;
        run_uop(u);
        u.form = opmvx;
        take_bits(32, r);
        u.rs1 = (r[31:0] << ew) | low_ones(ew);
        run_uop(u);
      end
    end
  endtask

  initial begin
    div_uop_t u;
    clk = 1'b0;
    rst_n = 1'b0;
    uop_valid = 1'b0;
    uop = '0;
    result_ready = 1'b0;
    lfsr = 32'd92347;
    checks = 0;
    errors = 0;
    timeouts = 0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;
    check_true(!result_valid, "result_valid high after reset");
    check_true(in_ready, "in_ready low after reset");
    for (int i = 0; i < n_vv && timeouts == 0; i++) begin
      make_uop(opmvv, u);
      run_uop(u);
    end
    for (int i = 0; i < n_vx && timeouts == 0; i++) begin
      make_uop(opmvx, u);
      run_uop(u);
    end
    zero_divisor_tests();
    overflow_tests();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/vdiv_chk.sv */
`default_nettype none
`timescale 1ns/1ps

module vdiv_chk (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  uop_valid,
  input logic                  in_ready,
  input logic                  result_valid,
  input logic                  result_ready,
  input vdiv_pkg::div_result_t result
);

  // strobe only while the unit is free
  a_offer_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
    uop_valid |-> in_ready)
    else $error("uop_valid high while in_ready is low");

  // stalled result must not move
  a_result_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (result_valid && !result_ready) |=> $stable(result))
    else $error("result changed while result_ready was low");

  // busy from the accept edge until the transfer
  a_busy_until_transfer: assert property (@(posedge clk) disable iff (!rst_n)
    ((uop_valid && in_ready) || (!in_ready && !(result_valid && result_ready)))
      |=> !in_ready)
    else $error("in_ready rose before the result transferred");

  // high from the 34th edge on so first seen at the 35th
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (uop_valid && in_ready) |-> ##35 $rose(result_valid))
    else $error("result_valid did not rise 34 cycles after accept");

endmodule

`default_nettype wire

/* src/vdiv_unit.sv */
`default_nettype none
`timescale 1ns/1ps

module vdiv_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  uop_valid,
  input  vdiv_pkg::div_uop_t    uop,
  output logic                  in_ready,
  output logic                  result_valid,
  output vdiv_pkg::div_result_t result,
  input  logic                  result_ready
);

  import vdiv_pkg::*;

  div_uop_t                 held_uop;
  lane_ops_t                ops;
  lane_res_t                res;
  logic                     is_signed;
  logic                     start;
  logic                     clear;
  logic [7:0]               done;
  logic [rob_tag_width-1:0] rob_entry;

  vdiv_uop_reg u_uop_reg (
    .clk          (clk),
    .rst_n        (rst_n),
    .uop_valid    (uop_valid),
    .uop          (uop),
    .in_ready     (in_ready),
    .held_uop     (held_uop),
    .start        (start),
    .clear        (clear),
    .done         (done),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .rob_entry    (rob_entry)
  );

  vdiv_operand_prep u_operand_prep (
    .held_uop  (held_uop),
    .ops       (ops),
    .is_signed (is_signed)
  );

  for (genvar j = 0; j < n_div8; j++) begin : g_div8
    vdiv_lane_divider #(.DIV_WIDTH(8)) u_div (
      .clk (clk), .rst_n (rst_n), .start (start), .clear (clear), .is_signed (is_signed),
      .dividend (ops.dividend8[j]), .divisor (ops.divisor8[j]),
      .quotient (res.quotient8[j]), .remainder (res.remainder8[j]), .done (done[j])
    );
  end

  for (genvar j = 0; j < n_div16; j++) begin : g_div16
    vdiv_lane_divider #(.DIV_WIDTH(16)) u_div (
      .clk (clk), .rst_n (rst_n), .start (start), .clear (clear), .is_signed (is_signed),
      .dividend (ops.dividend16[j]), .divisor (ops.divisor16[j]),
      .quotient (res.quotient16[j]), .remainder (res.remainder16[j]),
      .done (done[n_div8 + j])
    );
  end

  // 32-bit slots finish last
  for (genvar j = 0; j < n_div32; j++) begin : g_div32
    vdiv_lane_divider #(.DIV_WIDTH(32)) u_div (
      .clk (clk), .rst_n (rst_n), .start (start), .clear (clear), .is_signed (is_signed),
      .dividend (ops.dividend32[j]), .divisor (ops.divisor32[j]),
      .quotient (res.quotient32[j]), .remainder (res.remainder32[j]),
      .done (done[n_div8 + n_div16 + j])
    );
  end

  vdiv_result_pack u_result_pack (
    .res    (res),
    .op     (held_uop.op),
    .eew    (held_uop.eew),
    .w_data (result.w_data)
  );

  assign result.rob_entry = rob_entry;

endmodule

`default_nettype wire

/* src/vdiv_result_pack.sv */
`default_nettype none
`timescale 1ns/1ps

module vdiv_result_pack (
  input  vdiv_pkg::lane_res_t res,
  input  vdiv_pkg::div_op_e   op,
  input  vdiv_pkg::eew_e      eew,
  output vdiv_pkg::vreg_u     w_data
);

  import vdiv_pkg::*;

  logic                     sel_rem;
  logic [n_div8-1:0][7:0]   r8;
  logic [n_div16-1:0][15:0] r16;
  logic [n_div32-1:0][31:0] r32;

  assign sel_rem = (op == vremu) || (op == vrem);

  assign r8 = sel_rem ? res.remainder8 : res.quotient8;
  assign r16 = sel_rem ? res.remainder16 : res.quotient16;
  assign r32 = sel_rem ? res.remainder32 : res.quotient32;

  // low eew bits of each divider back into place
  always_comb begin
    w_data = '0;
    case (eew)
      eew8: begin
        for (int j = 0; j < n_div8; j++) begin
          w_data.b[j] = r8[j];
        end
        for (int j = 0; j < n_div16; j++) begin
          w_data.b[n_div8 + j] = r16[j][7:0];
        end
        for (int j = 0; j < n_div32; j++) begin
          w_data.b[n_div8 + n_div16 + j] = r32[j][7:0];
        end
      end
      eew16: begin
        for (int j = 0; j < n_div16; j++) begin
          w_data.h[j] = r16[j];
        end
        for (int j = 0; j < n_div32; j++) begin
          w_data.h[n_div16 + j] = r32[j][15:0];
        end
      end
      default: begin
        for (int j = 0; j < n_div32; j++) begin
          w_data.w[j] = r32[j];
        end
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/vdiv_lane_divider.sv */
`default_nettype none
`timescale 1ns/1ps

module vdiv_lane_divider #(
  parameter int DIV_WIDTH = 8
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  logic                 clear,
  input  logic                 is_signed,
  input  logic [DIV_WIDTH-1:0] dividend,
  input  logic [DIV_WIDTH-1:0] divisor,
  output logic [DIV_WIDTH-1:0] quotient,
  output logic [DIV_WIDTH-1:0] remainder,
  output logic                 done
);

  localparam int cnt_w = $clog2(DIV_WIDTH);

  typedef enum logic [1:0] {
    st_idle,
    st_run,
    st_fix,
    st_done
  } state_e;

  state_e             state;
  logic [cnt_w-1:0]   cnt;
  logic [DIV_WIDTH-1:0] part_rem;
  logic [DIV_WIDTH-1:0] quo_sh;
  logic [DIV_WIDTH-1:0] div_mag;
  logic [DIV_WIDTH-1:0] dividend_raw;
  logic               neg_quo;
  logic               neg_rem;
  logic               div_zero;
  logic               a_neg;
  logic               b_neg;
  logic [DIV_WIDTH-1:0] a_mag;
  logic [DIV_WIDTH-1:0] b_mag;
  logic [DIV_WIDTH:0] rem_shift;
  logic [DIV_WIDTH:0] trial;

  assign a_neg = is_signed & dividend[DIV_WIDTH-1];
  assign b_neg = is_signed & divisor[DIV_WIDTH-1];
  assign a_mag = a_neg ? -dividend : dividend;
  assign b_mag = b_neg ? -divisor : divisor;

  // shift in next dividend bit, try subtract
  assign rem_shift = {part_rem, quo_sh[DIV_WIDTH-1]};
  assign trial = rem_shift - {1'b0, div_mag};

  assign done = (state == st_done);

  // load, DIV_WIDTH steps, sign fix
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      cnt <= '0;
    end else if (clear) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_run;
            cnt <= cnt_w'(DIV_WIDTH - 1);
          end
        end
        st_run: begin
          if (cnt == '0) begin
            state <= st_fix;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        st_fix:  state <= st_done;
        default: state <= st_done;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      st_idle: begin
        if (start) begin
          part_rem <= '0;
          quo_sh <= a_mag;
          div_mag <= b_mag;
          dividend_raw <= dividend;
          neg_quo <= a_neg ^ b_neg;
          neg_rem <= a_neg;
          div_zero <= (divisor == '0);
        end
      end
      st_run: begin
        quo_sh <= {quo_sh[DIV_WIDTH-2:0], ~trial[DIV_WIDTH]};
        if (!trial[DIV_WIDTH]) begin
          part_rem <= trial[DIV_WIDTH-1:0];
        end else begin
          part_rem <= rem_shift[DIV_WIDTH-1:0];
        end
      end
      st_fix: begin
        // overflow case falls out of the negation
        if (div_zero) begin
          quotient <= '1;
          remainder <= dividend_raw;
        end else begin
          quotient <= neg_quo ? -quo_sh : quo_sh;
          remainder <= neg_rem ? -part_rem : part_rem;
        end
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/vdiv_operand_prep.sv */
`default_nettype none
`timescale 1ns/1ps

module vdiv_operand_prep (
  input  vdiv_pkg::div_uop_t  held_uop,
  output vdiv_pkg::lane_ops_t ops,
  output logic                is_signed
);

  import vdiv_pkg::*;

  logic vx_form;

  // element idx of a register, zero above eew
  function automatic logic [xlen-1:0] pick(vreg_u v, eew_e eew, int idx);
    logic [xlen-1:0] e;
    case (eew)
      eew8:    e = {{(xlen-8){1'b0}}, v.b[idx]};
      eew16:   e = {{(xlen-16){1'b0}}, v.h[idx]};
      default: e = v.w[idx];
    endcase
    return e;
  endfunction

  // widen the low eew bits to xlen
  function automatic logic [xlen-1:0] extend(logic [xlen-1:0] e, eew_e eew, logic sgn);
    logic [xlen-1:0] x;
    case (eew)
      eew8:    x = {{(xlen-8){sgn & e[7]}}, e[7:0]};
      eew16:   x = {{(xlen-16){sgn & e[15]}}, e[15:0]};
      default: x = e;
    endcase
    return x;
  endfunction

  assign is_signed = (held_uop.op == vdiv) || (held_uop.op == vrem);
  assign vx_form = (held_uop.form == opmvx);

  always_comb begin
    int base16;
    int base32;
    logic [xlen-1:0] a_e;
    logic [xlen-1:0] b_e;

    ops = '0;
    base16 = (held_uop.eew == eew8) ? n_div8 : 0;
    case (held_uop.eew)
      eew8:    base32 = n_div8 + n_div16;
      eew16:   base32 = n_div16;
      default: base32 = 0;
    endcase

    // byte dividers only see eew8
    if (held_uop.eew == eew8) begin
      for (int j = 0; j < n_div8; j++) begin
        a_e = pick(held_uop.vs2, held_uop.eew, j);
        b_e = vx_form ? held_uop.rs1 : pick(held_uop.vs1, held_uop.eew, j);
        ops.dividend8[j] = a_e[7:0];
        ops.divisor8[j] = b_e[7:0];
      end
    end

    if (held_uop.eew != eew32) begin
      for (int j = 0; j < n_div16; j++) begin
        a_e = extend(pick(held_uop.vs2, held_uop.eew, base16 + j), held_uop.eew, is_signed);
        b_e = vx_form ? held_uop.rs1 : pick(held_uop.vs1, held_uop.eew, base16 + j);
        b_e = extend(b_e, held_uop.eew, is_signed);
        ops.dividend16[j] = a_e[15:0];
        ops.divisor16[j] = b_e[15:0];
      end
    end

    for (int j = 0; j < n_div32; j++) begin
      a_e = extend(pick(held_uop.vs2, held_uop.eew, base32 + j), held_uop.eew, is_signed);
      b_e = vx_form ? held_uop.rs1 : pick(held_uop.vs1, held_uop.eew, base32 + j);
      ops.dividend32[j] = a_e;
      ops.divisor32[j] = extend(b_e, held_uop.eew, is_signed);
    end
  end

endmodule

`default_nettype wire

/* src/vdiv_uop_reg.sv */
`default_nettype none
`timescale 1ns/1ps

module vdiv_uop_reg (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 uop_valid,
  input  vdiv_pkg::div_uop_t                   uop,
  output logic                                 in_ready,
  output vdiv_pkg::div_uop_t                   held_uop,
  output logic                                 start,
  output logic                                 clear,
  input  logic [7:0]                           done,
  output logic                                 result_valid,
  input  logic                                 result_ready,
  output logic [vdiv_pkg::rob_tag_width-1:0]   rob_entry
);

  logic busy;
  logic accept;
  logic transfer;
  logic all_done;

  // one uop in flight at a time
  assign in_ready = !busy;
  assign accept = uop_valid & in_ready;

  assign all_done = &done;

  // busy masks the stale done bits in the cycle after a transfer
  assign result_valid = busy & all_done;
  assign transfer = result_valid & result_ready;

  assign rob_entry = held_uop.rob_entry;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
    end else if (accept) begin
      busy <= 1'b1;
    end else if (transfer) begin
      busy <= 1'b0;
    end
  end

  // start one cycle after accept, clear one cycle after transfer
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start <= 1'b0;
      clear <= 1'b0;
    end else begin
      start <= accept;
      clear <= transfer;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      held_uop <= uop;
    end
  end

endmodule

`default_nettype wire

/* src/vdiv_pkg.sv */
`default_nettype none

package vdiv_pkg;

  localparam int vlen = 64;
  localparam int vlenb = vlen / 8;
  localparam int xlen = 32;
  localparam int rob_tag_width = 4;

  // divider slots per width
  localparam int n_div8 = 4;
  localparam int n_div16 = 2;
  localparam int n_div32 = 2;

  // funct6 of the integer divide group
  typedef enum logic [5:0] {
    vdivu = 6'b100000,
    vdiv  = 6'b100001,
    vremu = 6'b100010,
    vrem  = 6'b100011
  } div_op_e;

  // funct3 operand forms
  typedef enum logic [2:0] {
    opmvv = 3'b010,
    opmvx = 3'b110
  } src_form_e;

  typedef enum logic [1:0] {
    eew8  = 2'b00,
    eew16 = 2'b01,
    eew32 = 2'b10
  } eew_e;

  // one vector register, seen per element width
  typedef union packed {
    logic [vlenb-1:0][7:0]          b;
    logic [vlen/16-1:0][15:0]       h;
    logic [vlen/xlen-1:0][xlen-1:0] w;
  } vreg_u;

  typedef struct packed {
    logic [rob_tag_width-1:0] rob_entry;
    div_op_e                  op;
    src_form_e                form;
    eew_e                     eew;
    vreg_u                    vs1;
    vreg_u                    vs2;
    logic [xlen-1:0]          rs1;
  } div_uop_t;

  typedef struct packed {
    logic [rob_tag_width-1:0] rob_entry;
    vreg_u                    w_data;
  } div_result_t;

  typedef struct packed {
    logic [n_div8-1:0][7:0]   dividend8;
    logic [n_div16-1:0][15:0] dividend16;
    logic [n_div32-1:0][31:0] dividend32;
    logic [n_div8-1:0][7:0]   divisor8;
    logic [n_div16-1:0][15:0] divisor16;
    logic [n_div32-1:0][31:0] divisor32;
  } lane_ops_t;

  typedef struct packed {
    logic [n_div8-1:0][7:0]   quotient8;
    logic [n_div16-1:0][15:0] quotient16;
    logic [n_div32-1:0][31:0] quotient32;
    logic [n_div8-1:0][7:0]   remainder8;
    logic [n_div16-1:0][15:0] remainder16;
    logic [n_div32-1:0][31:0] remainder32;
  } lane_res_t;

endpackage

`default_nettype wire
